//--- bicubic_upscaler.f
rtl/bicubic_pkg.sv
rtl/line_buffer.sv
rtl/window_buffer.sv
rtl/row_interp.sv
rtl/col_interp.sv
rtl/quad_merge.sv
rtl/bicubic_upscaler.sv
test/tb_bicubic_upscaler.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the run from its log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_bicubic_upscaler \
    -f bicubic_upscaler.f -o tb_bicubic_upscaler > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_bicubic_upscaler > "$LOG" 2>&1 \
    || echo "simulator exited with an error status" >> "$LOG"
cat "$LOG"

grep -q '^\*\* FAIL \*\*$' "$LOG" && { echo "simulation failed"; exit 1; }
grep -q '^\*\* PASS \*\*$' "$LOG" && { echo "simulation passed"; exit 0; } \
    || { echo "no result found in $LOG"; exit 1; }

//--- test/tb_bicubic_upscaler.sv
`timescale 1ns/100ps

module tb_bicubic_upscaler;

    localparam int IMG_WIDTH     = 16;
    localparam int IMG_HEIGHT    = 12;
    localparam int N_TESTS       = 7;
    localparam int RAMP_STEP     = 8;
    localparam int QUAD_TIMEOUT  = 200;
    localparam int SETTLE_CYCLES = 8;

    typedef enum int {PAT_CONST, PAT_HRAMP, PAT_VSTEP, PAT_CHECKER, PAT_RANDOM} pattern_e;

    logic                clk;
    logic                rst_n;
    logic                pix_valid;
    bicubic_pkg::pixel_t pix_data;
    bicubic_pkg::quad_t  quad;
    logic                quad_valid;
    logic                quad_last;

    bicubic_pkg::quad_t  exp_quad [$];
    bit                  exp_last [$];
    bicubic_pkg::quad_t  got_quad [$];
    bit                  got_last [$];
    int                  img [2][IMG_HEIGHT][IMG_WIDTH];
    int                  error_count = 0;
    int                  pass_count  = 0;
    int                  fail_count  = 0;

    // ==============================
    // stimulus table
    // ==============================

    string    tbl_name   [N_TESTS] = '{"constant_mid", "constant_white", "horizontal_ramp",
                                       "vertical_step", "checkerboard", "random_gapped",
                                       "random_back_to_back"};
    pattern_e tbl_kind   [N_TESTS] = '{PAT_CONST, PAT_CONST, PAT_HRAMP, PAT_VSTEP,
                                       PAT_CHECKER, PAT_RANDOM, PAT_RANDOM};
    int       tbl_base   [N_TESTS] = '{100, 255, 10, 0, 30, 0, 0};
    bit       tbl_gap    [N_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
    int       tbl_frames [N_TESTS] = '{1, 1, 1, 1, 1, 1, 2};
    int       tbl_quads  [N_TESTS] = '{117, 117, 117, 117, 117, 117, 234};  // 9 x 13 per frame.

    bicubic_upscaler #(
        .IMG_WIDTH (IMG_WIDTH),
        .IMG_HEIGHT(IMG_HEIGHT)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .quad      (quad),
        .quad_valid(quad_valid),
        .quad_last (quad_last)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (rst_n && quad_valid) begin
            got_quad.push_back(quad);
            got_last.push_back(quad_last);
        end
    end

    // ==============================
    // reference model
    // ==============================

    function automatic int kernel_half(input int p0, input int p1, input int p2, input int p3);
        int sum;
        sum = 9 * (p1 + p2) - p0 - p3 + 8;
        if (sum < 0) begin
            return 0;
        end
        sum = sum / 16;
        if (sum > 255) begin
            return 255;
        end
        return sum;
    endfunction

    function automatic int pattern_pixel(input pattern_e kind, input int base,
                                         input int r, input int c);
        case (kind)
            PAT_CONST:   return base;
            PAT_HRAMP:   return base + RAMP_STEP * c;
            PAT_VSTEP:   return (r < IMG_HEIGHT / 2) ? base : 255 - base;
            PAT_CHECKER: return ((r + c) % 2 == 0) ? base : 255 - base;
            default:     return int'($urandom_range(255, 0));
        endcase
    endfunction

    // window at strobe (r, c) covers rows r-3..r and columns c-3..c.
    task automatic build_expected(input int f);
        int                 v [4];
        bicubic_pkg::quad_t eq;
        for (int r = 3; r < IMG_HEIGHT; r++) begin
            for (int c = 3; c < IMG_WIDTH; c++) begin
                for (int k = 0; k < 4; k++) begin
                    v[k] = kernel_half(img[f][r-3][c-3+k], img[f][r-2][c-3+k],
                                       img[f][r-1][c-3+k], img[f][r][c-3+k]);
                end
                eq.orig   = 8'(img[f][r-2][c-2]);
                eq.horiz  = 8'(kernel_half(img[f][r-2][c-3], img[f][r-2][c-2],
                                           img[f][r-2][c-1], img[f][r-2][c]));
                eq.vert   = 8'(v[1]);
                eq.center = 8'(kernel_half(v[0], v[1], v[2], v[3]));
                exp_quad.push_back(eq);
                exp_last.push_back((r == IMG_HEIGHT - 1) && (c == IMG_WIDTH - 1));
            end
        end
    endtask

    // ==============================
    // drive, wait and check
    // ==============================

    task automatic send_pixel(input int value);
        @(posedge clk);
        pix_valid <= 1'b1;
        pix_data  <= 8'(value);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        pix_valid <= 1'b0;
    endtask

    task automatic wait_for_quads(input int count, output bit timed_out);
        int cycles;
        cycles    = 0;
        timed_out = 1'b0;
        while (got_quad.size() < count && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles > QUAD_TIMEOUT) begin
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic compare_value(input string test_name, input string field,
                                 input int expected, input int actual);
        if (expected != actual) begin
            $display("Error: %s %s expected %0d actual %0d", test_name, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int quads, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %s: %0d quads, ok", name, quads);
        end else begin
            fail_count++;
            $display("test %s: %0d quads, %0d errors", name, quads, error_count - errors_before);
        end
    endtask

    task automatic run_test(input int t);
        int                 errors_before;
        int                 n;
        bit                 timed_out;
        bicubic_pkg::quad_t got;
        bicubic_pkg::quad_t want;
        errors_before = error_count;
        exp_quad.delete();
        exp_last.delete();
        got_quad.delete();
        got_last.delete();
        for (int f = 0; f < tbl_frames[t]; f++) begin
            for (int r = 0; r < IMG_HEIGHT; r++) begin
                for (int c = 0; c < IMG_WIDTH; c++) begin
                    img[f][r][c] = pattern_pixel(tbl_kind[t], tbl_base[t], r, c);
                end
            end
            build_expected(f);
        end
        for (int f = 0; f < tbl_frames[t]; f++) begin
            for (int r = 0; r < IMG_HEIGHT; r++) begin
                for (int c = 0; c < IMG_WIDTH; c++) begin
                    if (tbl_gap[t]) begin
                        repeat ($urandom_range(3, 0)) idle_cycle();
                    end
                    send_pixel(img[f][r][c]);
                end
            end
        end
        idle_cycle();
        wait_for_quads(exp_quad.size(), timed_out);
        if (timed_out) begin
            $display("test %s timed out waiting for quads, got %0d of %0d",
                     tbl_name[t], got_quad.size(), exp_quad.size());
            error_count++;
        end
        repeat (SETTLE_CYCLES) @(negedge clk);  // any surplus quad shows up in the count.
        compare_value(tbl_name[t], "quad count", tbl_quads[t], got_quad.size());
        n = (got_quad.size() < exp_quad.size()) ? got_quad.size() : exp_quad.size();
        for (int i = 0; i < n; i++) begin
            got  = got_quad[i];
            want = exp_quad[i];
            compare_value(tbl_name[t], $sformatf("quad %0d orig", i),
                          int'(want.orig), int'(got.orig));
            compare_value(tbl_name[t], $sformatf("quad %0d horiz", i),
                          int'(want.horiz), int'(got.horiz));
            compare_value(tbl_name[t], $sformatf("quad %0d vert", i),
                          int'(want.vert), int'(got.vert));
            compare_value(tbl_name[t], $sformatf("quad %0d center", i),
                          int'(want.center), int'(got.center));
            compare_value(tbl_name[t], $sformatf("quad %0d last", i),
                          int'(exp_last[i]), int'(got_last[i]));
            if (tbl_kind[t] == PAT_HRAMP) begin
                // a linear ramp interpolates to the exact midpoint.
                compare_value(tbl_name[t], $sformatf("quad %0d ramp horiz", i),
                              int'(want.orig) + RAMP_STEP / 2, int'(got.horiz));
                compare_value(tbl_name[t], $sformatf("quad %0d ramp vert", i),
                              int'(want.orig), int'(got.vert));
            end
        end
        report_test(tbl_name[t], got_quad.size(), errors_before);
    endtask

    initial begin
        int errors_before;
        void'($urandom(32'h7385eb6e));
        rst_n     = 1'b0;
        pix_valid = 1'b0;
        pix_data  = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        errors_before = error_count;
        repeat (SETTLE_CYCLES) begin
            @(negedge clk);
            compare_value("reset_idle", "quad_valid", 0, int'(quad_valid));
            compare_value("reset_idle", "quad_last", 0, int'(quad_last));
        end
        report_test("reset_idle", 0, errors_before);

        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- rtl/bicubic_upscaler.sv
`timescale 1ns/100ps

module bicubic_upscaler #(
    parameter int IMG_WIDTH  = 16,
    parameter int IMG_HEIGHT = 12
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pix_valid,
    input  bicubic_pkg::pixel_t pix_data,
    output bicubic_pkg::quad_t  quad,
    output logic                quad_valid,
    output logic                quad_last
);

    bicubic_pkg::win_t   win;
    logic                win_valid;
    logic                win_last;
    bicubic_pkg::pixel_t h_pix;
    logic                v_valid;
    logic                v_last;
    bicubic_pkg::vset_t  v_set;
    bicubic_pkg::pixel_t o_pix;

    window_buffer #(
        .IMG_WIDTH (IMG_WIDTH),
        .IMG_HEIGHT(IMG_HEIGHT)
    ) u_window_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix_valid(pix_valid),
        .pix_data (pix_data),
        .win      (win),
        .win_valid(win_valid),
        .win_last (win_last)
    );

    // the merge stage takes h_pix on v_valid, so h_valid is left open.
    row_interp u_row_interp (
        .clk      (clk),
        .rst_n    (rst_n),
        .win_valid(win_valid),
        .win      (win),
        .h_valid  (),
        .h_pix    (h_pix)
    );

    col_interp u_col_interp (
        .clk      (clk),
        .rst_n    (rst_n),
        .win_valid(win_valid),
        .win_last (win_last),
        .win      (win),
        .v_valid  (v_valid),
        .v_last   (v_last),
        .v_set    (v_set),
        .o_pix    (o_pix)
    );

    quad_merge u_quad_merge (
        .clk       (clk),
        .rst_n     (rst_n),
        .v_valid   (v_valid),
        .v_last    (v_last),
        .v_set     (v_set),
        .o_pix     (o_pix),
        .h_pix     (h_pix),
        .quad      (quad),
        .quad_valid(quad_valid),
        .quad_last (quad_last)
    );

endmodule

//--- rtl/quad_merge.sv
`timescale 1ns/100ps

module quad_merge (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                v_valid,
    input  logic                v_last,
    input  bicubic_pkg::vset_t  v_set,
    input  bicubic_pkg::pixel_t o_pix,
    input  bicubic_pkg::pixel_t h_pix,
    output bicubic_pkg::quad_t  quad,
    output logic                quad_valid,
    output logic                quad_last
);

    bicubic_pkg::pixel_t center;

    // filtering the vertical results across the row gives the diagonal sample.
    assign center = bicubic_pkg::half_tap(v_set[0], v_set[1], v_set[2], v_set[3]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quad_valid <= 1'b0;
            quad_last  <= 1'b0;
        end else begin
            quad_valid <= v_valid;
            quad_last  <= v_valid && v_last;
        end
    end

    always_ff @(posedge clk) begin
        if (v_valid) begin
            quad.orig   <= o_pix;
            quad.horiz  <= h_pix;     // row_interp output lines up with v_valid.
            quad.vert   <= v_set[1];
            quad.center <= center;
        end
    end

    a_last_with_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        quad_last |-> quad_valid
    ) else $error("quad_last raised without quad_valid");

endmodule

//--- rtl/col_interp.sv
`timescale 1ns/100ps

module col_interp (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                win_valid,
    input  logic                win_last,
    input  bicubic_pkg::win_t   win,
    output logic                v_valid,
    output logic                v_last,
    output bicubic_pkg::vset_t  v_set,
    output bicubic_pkg::pixel_t o_pix
);

    bicubic_pkg::vset_t v_next;

    // one kernel per column, between window rows 1 and 2.
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            v_next[c] = bicubic_pkg::half_tap(
                win.row0[c],
                win.row1[c],
                win.row2[c],
                win.row3[c]
            );
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_valid <= 1'b0;
            v_last  <= 1'b0;
        end else begin
            v_valid <= win_valid;
            v_last  <= win_valid && win_last;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            v_set <= v_next;
            o_pix <= win.row1[1];  // source pixel travels with its interpolations.
        end
    end

endmodule

//--- rtl/row_interp.sv
`timescale 1ns/100ps

module row_interp (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                win_valid,
    input  bicubic_pkg::win_t   win,
    output logic                h_valid,
    output bicubic_pkg::pixel_t h_pix
);

    bicubic_pkg::pixel_t h_next;

    // half-pixel between columns 1 and 2 of window row 1.
    assign h_next = bicubic_pkg::half_tap(
        win.row1[0],
        win.row1[1],
        win.row1[2],
        win.row1[3]
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_valid <= 1'b0;
        end else begin
            h_valid <= win_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            h_pix <= h_next;
        end
    end

endmodule

//--- rtl/window_buffer.sv
`timescale 1ns/100ps

module window_buffer #(
    parameter int IMG_WIDTH  = 16,
    parameter int IMG_HEIGHT = 12
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pix_valid,
    input  bicubic_pkg::pixel_t pix_data,
    output bicubic_pkg::win_t   win,
    output logic                win_valid,
    output logic                win_last
);

    localparam int COL_W = $clog2(IMG_WIDTH);
    localparam int ROW_W = $clog2(IMG_HEIGHT);

    logic [COL_W-1:0]    col_cnt;
    logic [ROW_W-1:0]    row_cnt;
    logic                col_end;
    logic                row_end;
    logic                full_win;
    bicubic_pkg::row_t   rows [4];
    bicubic_pkg::pixel_t lb_dout [3];

    // ==============================
    // position counters
    // ==============================

    assign col_end  = (col_cnt == COL_W'(IMG_WIDTH - 1));
    assign row_end  = (row_cnt == ROW_W'(IMG_HEIGHT - 1));
    assign full_win = (col_cnt >= COL_W'(3)) && (row_cnt >= ROW_W'(3));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (pix_valid) begin
            if (col_end) begin
                col_cnt <= '0;
                row_cnt <= row_end ? '0 : row_cnt + 1'b1;  // wraps so frames can run back to back.
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end else begin
            win_valid <= pix_valid && full_win;
            win_last  <= pix_valid && col_end && row_end;
        end
    end

    // ==============================
    // line memories and shift rows
    // ==============================

    // each memory is fed from the oldest tap of the row below it.
    for (genvar i = 0; i < 3; i++) begin : g_line
        line_buffer #(
            .IMG_WIDTH(IMG_WIDTH)
        ) u_line_buffer (
            .clk     (clk),
            .rst_n   (rst_n),
            .shift_en(pix_valid),
            .din     (rows[i+1][0]),
            .dout    (lb_dout[i])
        );
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            rows[3] <= {pix_data, rows[3][3:1]};  // column 3 takes the newest pixel.
            for (int i = 0; i < 3; i++) begin
                rows[i] <= {lb_dout[i], rows[i][3:1]};
            end
        end
    end

    assign win = {rows[0], rows[1], rows[2], rows[3]};

    a_col_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(col_cnt) < IMG_WIDTH
    ) else $error("column counter left the image width");

    // a window only follows the strobe of the pixel that completes it.
    a_valid_after_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(win_valid) |-> $past(pix_valid)
    ) else $error("win_valid rose without an input strobe");

endmodule

//--- rtl/line_buffer.sv
`timescale 1ns/100ps

module line_buffer #(
    parameter int IMG_WIDTH = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                shift_en,
    input  bicubic_pkg::pixel_t din,
    output bicubic_pkg::pixel_t dout
);

    // the shift row in front of this memory adds the other four stages of the line.
    localparam int DEPTH = IMG_WIDTH - 4;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    bicubic_pkg::pixel_t mem [DEPTH];
    logic [PTR_W-1:0]    ptr;

    assign dout = mem[ptr];  // oldest entry, replaced by din on the next shift.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (shift_en) begin
            ptr <= (ptr >= PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (shift_en) begin
            mem[ptr] <= din;
        end
    end

endmodule

//--- rtl/bicubic_pkg.sv
package bicubic_pkg;

    // ==============================
    // pixel and window types
    // ==============================

    typedef logic [7:0] pixel_t;            // one luminance sample.
    typedef logic signed [13:0] tap_acc_t;  // holds the full kernel sum with sign.

    typedef pixel_t [3:0] row_t;            // the index is the window column.

    typedef struct packed {
        row_t row0;                         // oldest line.
        row_t row1;
        row_t row2;
        row_t row3;                         // line being received now.
    } win_t;

    typedef pixel_t [3:0] vset_t;           // vertical half-pixel per column.

    typedef struct packed {
        pixel_t orig;
        pixel_t horiz;
        pixel_t vert;
        pixel_t center;
    } quad_t;

    // ==============================
    // bicubic kernel at phase one half
    // ==============================

    function automatic pixel_t half_tap(
        input pixel_t p0,
        input pixel_t p1,
        input pixel_t p2,
        input pixel_t p3
    );
        tap_acc_t inner;
        tap_acc_t outer;
        tap_acc_t acc;
        inner = {6'd0, p1} + {6'd0, p2};
        outer = {6'd0, p0} + {6'd0, p3};
        acc   = (inner <<< 3) + inner - outer + 14'sd8;  // weights -1, 9, 9, -1 plus rounding.
        acc   = acc >>> 4;
        if (acc < 0) begin
            return 8'd0;
        end else if (acc > 14'sd255) begin
            return 8'd255;
        end
        return pixel_t'(acc);
    endfunction

endpackage
